/* bench/rv_core_properties.sv */
`timescale 1ns/1ns
`include "rv_core_defs.svh"

module rv_core_properties import rv_bus_pkg::*; (
    input logic                clk,
    input logic                resetn,
    input logic                trap,
    input logic                mem_valid,
    input logic                mem_instr,
    input logic                mem_ready,
    input logic [`RV_XLEN-1:0] mem_addr,
    input logic [`RV_XLEN-1:0] mem_wdata,
    input wstrb_t              mem_wstrb
);

    int unsigned fails = 0;

    // request held until the slave takes it
    property valid_held;
        @(posedge clk) disable iff (!resetn)
        mem_valid && !mem_ready |=> mem_valid;
    endproperty

    property request_stable;
        @(posedge clk) disable iff (!resetn)
        mem_valid && !mem_ready |=> $stable(mem_addr) && $stable(mem_wdata) &&
                                    $stable(mem_wstrb) && $stable(mem_instr);
    endproperty

    property reset_values;
        @(posedge clk) !resetn |=> !mem_valid && !trap;
    endproperty

    // nothing leaves the core once trapped
    property quiet_after_trap;
        @(posedge clk) disable iff (!resetn)
        trap |=> !$rose(mem_valid);
    endproperty

    assert property (valid_held) else begin
        $error("mem_valid dropped before mem_ready");
        fails++;
    end
    assert property (request_stable) else begin
        $error("bus request changed during a stall");
        fails++;
    end
    assert property (reset_values) else begin
        $error("mem_valid or trap high after reset");
        fails++;
    end
    assert property (quiet_after_trap) else begin
        $error("new bus request after trap");
        fails++;
    end

endmodule

bind rv_core rv_core_properties props_i (.*);

/* bench/rv_core_tb.sv */
`timescale 1ns/1ns
`include "rv_core_defs.svh"

module rv_core_tb;

    logic        clk = 1'b0;
    logic        resetn;
    logic        mem_ready;
    logic [31:0] mem_rdata;
    logic        trap, mem_valid, mem_instr;
    logic [31:0] mem_addr, mem_wdata;
    logic [3:0]  mem_wstrb;

    logic [31:0] mem [0:4095];
    logic [31:0] exp_val [0:511];
    int          slot_test [0:511];
    int          test_last [0:3];
    int          test_err [0:5];
    string       test_name [0:5];
    logic [35:0] exp_wr [$];
    logic [35:0] wr;
    logic [31:0] v1, v2, v3, v4, v11, v12, w, a;
    logic        waiting;
    int seed = 66;
    int pc_b, n_slots, cur_test, stall, stalled, stores, checks, errors, cycles, slot, t, i;

    rv_core rv_core_i (
        .clk(clk), .resetn(resetn), .trap(trap),
        .mem_valid(mem_valid), .mem_instr(mem_instr), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
        .mem_ready(mem_ready), .mem_rdata(mem_rdata)
    );

    always #2 clk = ~clk;

    // *******************************************************************
    // instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    // branch outcome by funct3
    function automatic logic taken(input logic [2:0] f3, input logic [31:0] x, y);
        case (f3)
            3'd0:    return x == y;
            3'd1:    return x != y;
            3'd4:    return $signed(x) < $signed(y);
            3'd5:    return $signed(x) >= $signed(y);
            3'd6:    return x < y;
            default: return x >= y;
        endcase
    endfunction

    // *******************************************************************
    // program builder
    task automatic emit(input logic [31:0] word);
        mem[pc_b >> 2] = word;
        pc_b = pc_b + 4;
    endtask

    task automatic li(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = value + 32'h800;
        emit({hi[31:12], rd, 7'h37});
        emit(enc_i(value[11:0], rd, 3'd0, rd, 7'h13));
    endtask

    // sw to the result area at x31
    task automatic save(input logic [4:0] rs, input logic [31:0] expected);
        logic [11:0] off;
        off = 12'(n_slots * 4);
        emit(enc_s(off, rs, 5'd31, 3'd2));
        exp_val[n_slots] = expected;
        slot_test[n_slots] = cur_test;
        test_last[cur_test] = n_slots;
        n_slots = n_slots + 1;
    endtask

    task automatic rr_check(input logic [6:0] f7, input logic [2:0] f3,
                            input logic [4:0] rs1, rs2, input logic [31:0] expected);
        emit(enc_r(f7, rs2, rs1, f3, 5'd5));
        save(5'd5, expected);
    endtask

    task automatic ri_check(input logic [2:0] f3, input logic [4:0] rs1,
                            input logic [11:0] imm, input logic [31:0] expected);
        emit(enc_i(imm, rs1, f3, 5'd5, 7'h13));
        save(5'd5, expected);
    endtask

    // marker 1 when the branch skips, 3 when it falls through
    task automatic branch_check(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                input logic [31:0] x, y);
        emit(enc_i(12'd1, 5'd0, 3'd0, 5'd6, 7'h13));
        emit(enc_b(13'd8, rs2, rs1, f3));
        emit(enc_i(12'd3, 5'd0, 3'd0, 5'd6, 7'h13));
        save(5'd6, taken(f3, x, y) ? 32'd1 : 32'd3);
    endtask

    task automatic load_check(input logic [2:0] f3, input logic [11:0] off,
                              input logic [31:0] expected);
        emit(enc_i(off, 5'd10, f3, 5'd13, 7'h03));
        save(5'd13, expected);
    endtask

    task automatic build_program();
        v1 = -32'sd5;
        v2 = 32'd3;
        v3 = 32'h8000_0000;
        v4 = 32'h7fff_ffff;
        v11 = 32'h1122_3344;
        v12 = 32'h0000_80f6;
        pc_b = 0;
        n_slots = 0;
        emit({20'h00001, 5'd31, 7'h37});
        li(5'd1, v1);
        li(5'd2, v2);
        li(5'd3, v3);
        li(5'd4, v4);
        cur_test = 0;
        ri_check(3'd0, 5'd1, 12'd100, v1 + 32'd100);
        rr_check(7'h00, 3'd0, 5'd3, 5'd4, v3 + v4);
        rr_check(7'h20, 3'd0, 5'd2, 5'd1, v2 - v1);
        rr_check(7'h20, 3'd0, 5'd3, 5'd2, v3 - v2);
        rr_check(7'h00, 3'd4, 5'd1, 5'd4, v1 ^ v4);
        rr_check(7'h00, 3'd6, 5'd2, 5'd3, v2 | v3);
        rr_check(7'h00, 3'd7, 5'd1, 5'd4, v1 & v4);
        rr_check(7'h00, 3'd2, 5'd1, 5'd2, {31'b0, $signed(v1) < $signed(v2)});
        rr_check(7'h00, 3'd3, 5'd1, 5'd2, {31'b0, v1 < v2});
        rr_check(7'h00, 3'd2, 5'd3, 5'd4, {31'b0, $signed(v3) < $signed(v4)});
        rr_check(7'h00, 3'd2, 5'd4, 5'd3, {31'b0, $signed(v4) < $signed(v3)});
        rr_check(7'h00, 3'd3, 5'd3, 5'd4, {31'b0, v3 < v4});
        ri_check(3'd2, 5'd1, 12'hffc, {31'b0, $signed(v1) < -32'sd4});
        ri_check(3'd3, 5'd2, 12'hfff, {31'b0, v2 < 32'hffff_ffff});
        ri_check(3'd4, 5'd1, 12'hfff, v1 ^ 32'hffff_ffff);
        ri_check(3'd6, 5'd2, 12'h700, v2 | 32'h700);
        ri_check(3'd7, 5'd4, 12'h0f0, v4 & 32'h0f0);
        cur_test = 1;
        emit({20'habcde, 5'd5, 7'h37});
        save(5'd5, 32'habcde000);
        a = pc_b;
        emit({20'h12345, 5'd5, 7'h17});
        save(5'd5, a + 32'h1234_5000);
        cur_test = 2;
        for (i = 0; i < 8; i++) begin
            // funct3 2 and 3 are no branches
            if (i == 2 || i == 3)
                continue;
            branch_check(3'(i), 5'd1, 5'd2, v1, v2);
            branch_check(3'(i), 5'd2, 5'd1, v2, v1);
            branch_check(3'(i), 5'd1, 5'd1, v1, v1);
        end
        emit(enc_i(12'd1, 5'd0, 3'd0, 5'd6, 7'h13));
        a = pc_b;
        emit(enc_j(21'd8, 5'd7));
        emit(enc_i(12'd2, 5'd0, 3'd0, 5'd6, 7'h13));
        save(5'd7, a + 32'd4);
        save(5'd6, 32'd1);
        a = pc_b;
        emit({20'h0, 5'd8, 7'h17});
        emit(enc_i(12'd1, 5'd0, 3'd0, 5'd6, 7'h13));
        // odd offset so the target lands on a + 16
        emit(enc_i(12'd17, 5'd8, 3'd0, 5'd9, 7'h67));
        emit(enc_i(12'd2, 5'd0, 3'd0, 5'd6, 7'h13));
        save(5'd9, a + 32'd12);
        save(5'd6, 32'd1);
        cur_test = 3;
        emit({20'h00002, 5'd10, 7'h37});
        li(5'd11, v11);
        li(5'd12, v12);
        emit(enc_s(12'd0, 5'd11, 5'd10, 3'd2));
        exp_wr.push_back({4'b1111, v11});
        emit(enc_s(12'd1, 5'd12, 5'd10, 3'd0));
        exp_wr.push_back({4'b0010, {4{v12[7:0]}}});
        emit(enc_s(12'd2, 5'd12, 5'd10, 3'd1));
        exp_wr.push_back({4'b1100, {2{v12[15:0]}}});
        w = {v12[15:0], v12[7:0], v11[7:0]};
        load_check(3'd0, 12'd1, {{24{w[15]}}, w[15:8]});
        load_check(3'd4, 12'd1, {24'b0, w[15:8]});
        load_check(3'd1, 12'd2, {{16{w[31]}}, w[31:16]});
        load_check(3'd5, 12'd2, {16'b0, w[31:16]});
        load_check(3'd2, 12'd0, w);
        load_check(3'd0, 12'd0, {{24{w[7]}}, w[7:0]});
        // ecall is outside the supported subset
        emit(32'h0000_0073);
    endtask

    // *******************************************************************
    // memory model
    task automatic report_test(input int n);
        $display("test %0d %s: %s, %0d errors", n, test_name[n],
                 (test_err[n] == 0) ? "ok" : "failed", test_err[n]);
    endtask

    task automatic check_store();
        if (mem_addr >= 32'h1000 && mem_addr < 32'h1800) begin
            slot = (mem_addr - 32'h1000) >> 2;
            t = slot_test[slot];
            checks++;
            stores++;
            assert (mem_wstrb == 4'hf && mem_wdata == exp_val[slot]) else begin
                $display("error at %0t: mem_wdata slot %0d: got %h, expected %h",
                         $time, slot, mem_wdata, exp_val[slot]);
                test_err[t]++;
                errors++;
            end
            if (slot == test_last[t])
                report_test(t);
        end else if (exp_wr.size() == 0) begin
            $display("unexpected store to address %h", mem_addr);
            test_err[3]++;
            errors++;
        end else begin
            wr = exp_wr.pop_front();
            checks++;
            assert ({mem_wstrb, mem_wdata} == wr) else begin
                $display("error at %0t: mem_wstrb/mem_wdata: got %h/%h, expected %h/%h",
                         $time, mem_wstrb, mem_wdata, wr[35:32], wr[31:0]);
                test_err[3]++;
                errors++;
            end
        end
    endtask

    // program words sit below the result area
    task automatic check_instr_flag();
        checks++;
        assert (mem_instr == (mem_addr < 32'h1000)) else begin
            $display("error at %0t: mem_instr at address %h: got %b, expected %b",
                     $time, mem_addr, mem_instr, mem_addr < 32'h1000);
            test_err[5]++;
            errors++;
        end
    endtask

    always @(negedge clk) begin
        if (mem_ready) begin
            mem_ready = 1'b0;
            waiting = 1'b0;
        end else if (resetn && mem_valid) begin
            if (!waiting) begin
                waiting = 1'b1;
                stall = {$random(seed)} % 4;
                if (stall > 0)
                    stalled++;
            end
            if (stall > 0) begin
                stall--;
            end else begin
                check_instr_flag();
                mem_rdata = mem[mem_addr[13:2]];
                if (mem_wstrb != 4'b0) begin
                    for (i = 0; i < 4; i++)
                        if (mem_wstrb[i])
                            mem[mem_addr[13:2]][8*i +: 8] = mem_wdata[8*i +: 8];
                    check_store();
                end
                mem_ready = 1'b1;
            end
        end
    end

    // *******************************************************************
    // main sequence
    initial begin
        resetn = 1'b0;
        mem_ready = 1'b0;
        mem_rdata = '0;
        waiting = 1'b0;
        stall = 0;
        stalled = 0;
        stores = 0;
        checks = 0;
        errors = 0;
        test_name = '{"alu", "upper", "control", "load_store", "trap", "stalls"};
        test_err = '{0, 0, 0, 0, 0, 0};
        for (i = 0; i < 4096; i++)
            mem[i] = i * 32'h9e37_79b9;
        build_program();
        repeat (3) @(negedge clk);
        resetn = 1'b1;
        cycles = 0;
        while (!trap && cycles < 20000) begin
            @(negedge clk);
            cycles++;
        end
        if (!trap) begin
            $display("timeout: the core never raised trap");
            test_err[4]++;
            errors++;
        end else begin
            repeat (20) begin
                @(negedge clk);
                checks++;
                assert (!mem_valid) else begin
                    $display("bus request issued after trap at %0t", $time);
                    test_err[4]++;
                    errors++;
                end
            end
        end
        report_test(4);
        checks++;
        assert (stalled > 0) else begin
            $display("no transfer was ever stalled");
            test_err[5]++;
            errors++;
        end
        checks++;
        assert (rv_core_i.props_i.fails == 0) else begin
            $display("bound bus assertions failed %0d times", rv_core_i.props_i.fails);
            test_err[5]++;
            errors++;
        end
        report_test(5);
        checks++;
        assert (stores == n_slots && exp_wr.size() == 0) else begin
            $display("not every expected store reached the bus (%0d of %0d results)",
                     stores, n_slots);
            errors++;
        end
        $display("tests: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* include/rv_core_defs.svh */
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// datapath and address width
`define RV_XLEN 32

// first fetch after reset
`define RV_RESET_ADDR 32'h0000_0000

// architectural register file
`define RV_NREGS 32
`define RV_REG_IDX_W 5

`endif

/* rtl/rv_alu.sv */
`timescale 1ns/1ns
`include "rv_core_defs.svh"

module rv_alu import rv_isa_pkg::*; (
    input  alu_op_t             op,
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    output logic [`RV_XLEN-1:0] result,
    output logic                cond
);

    logic [`RV_XLEN-1:0] sum;
    logic [`RV_XLEN-1:0] diff;
    logic                borrow;
    logic                eq;
    logic                lts;

    assign sum              = a + b;
    // one subtractor feeds sub and both less-than flags
    assign {borrow, diff}   = {1'b0, a} - {1'b0, b};
    assign eq               = (a == b);
    assign lts              = (a[`RV_XLEN-1] != b[`RV_XLEN-1]) ? a[`RV_XLEN-1] : borrow;

    always_comb begin
        case (op)
            alu_sub:  result = diff;
            alu_slt:  result = {{(`RV_XLEN-1){1'b0}}, lts};
            alu_sltu: result = {{(`RV_XLEN-1){1'b0}}, borrow};
            alu_xor:  result = a ^ b;
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = sum;
        endcase
    end

    always_comb begin
        case (op)
            alu_eq:  cond = eq;
            alu_ne:  cond = !eq;
            alu_lt:  cond = lts;
            alu_ge:  cond = !lts;
            alu_ltu: cond = borrow;
            alu_geu: cond = !borrow;
            default: cond = 1'b0;
        endcase
    end

endmodule

/* rtl/rv_bus_pkg.sv */
package rv_bus_pkg;

    // access size of a data transfer
    typedef enum logic [1:0] {
        size_word = 2'd0,
        size_half = 2'd1,
        size_byte = 2'd2
    } mem_size_t;

    // one enable per byte lane
    typedef logic [3:0] wstrb_t;

endpackage

/* rtl/rv_core.sv */
`timescale 1ns/1ns
`include "rv_core_defs.svh"

module rv_core import rv_isa_pkg::*; import rv_bus_pkg::*; (
    input  logic                clk,
    input  logic                resetn,
    output logic                trap,
    output logic                mem_valid,
    output logic                mem_instr,
    output logic [`RV_XLEN-1:0] mem_addr,
    output logic [`RV_XLEN-1:0] mem_wdata,
    output wstrb_t              mem_wstrb,
    input  logic                mem_ready,
    input  logic [`RV_XLEN-1:0] mem_rdata
);

    localparam logic [5:0] st_fetch    = 6'b000001;
    localparam logic [5:0] st_decode   = 6'b000010;
    localparam logic [5:0] st_load_ops = 6'b000100;
    localparam logic [5:0] st_exec     = 6'b001000;
    localparam logic [5:0] st_mem      = 6'b010000;
    localparam logic [5:0] st_trap     = 6'b100000;

    logic [5:0]               state;
    logic                     busy;
    logic [`RV_XLEN-1:0]      pc, next_pc, op1, op2, result;
    logic [`RV_XLEN-1:0]      branch_target;

    instr_class_t             dec_iclass;
    alu_op_t                  dec_alu_op;
    logic [`RV_REG_IDX_W-1:0] dec_rd, dec_rs1, dec_rs2;
    logic [`RV_XLEN-1:0]      dec_imm;
    mem_size_t                dec_mem_size;
    logic                     dec_load_unsigned, dec_use_pc, dec_use_imm;

    logic [`RV_XLEN-1:0]      alu_result, rf_rdata1, rf_rdata2, rf_wdata;
    logic                     alu_cond, rf_we, is_link;
    logic                     seq_start, seq_done;
    logic [`RV_XLEN-1:0]      seq_rdata;

    // *******************************************************************
    // submodules
    rv_decoder decoder_i (
        .clk(clk), .resetn(resetn), .load(state == st_fetch && seq_done), .instr(seq_rdata),
        .iclass(dec_iclass), .alu_op(dec_alu_op), .rd(dec_rd), .rs1(dec_rs1), .rs2(dec_rs2),
        .imm(dec_imm), .mem_size(dec_mem_size), .load_unsigned(dec_load_unsigned),
        .use_pc(dec_use_pc), .use_imm(dec_use_imm)
    );

    rv_alu alu_i (.op(dec_alu_op), .a(op1), .b(op2), .result(alu_result), .cond(alu_cond));

    rv_regfile regfile_i (
        .clk(clk), .we(rf_we), .waddr(dec_rd), .wdata(rf_wdata),
        .raddr1(dec_rs1), .raddr2(dec_rs2), .rdata1(rf_rdata1), .rdata2(rf_rdata2)
    );

    // fetch reads at next_pc, the memory phase at the computed address
    rv_mem_sequencer mem_seq_i (
        .clk(clk), .resetn(resetn), .start(seq_start),
        .write(state == st_mem && dec_iclass == cls_store), .instr(state == st_fetch),
        .size(state == st_mem ? dec_mem_size : size_word), .load_unsigned(dec_load_unsigned),
        .addr(state == st_mem ? result : next_pc), .wdata(rf_rdata2),
        .done(seq_done), .rdata(seq_rdata),
        .mem_valid(mem_valid), .mem_instr(mem_instr), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
        .mem_ready(mem_ready), .mem_rdata(mem_rdata)
    );

    assign seq_start     = (state == st_fetch || state == st_mem) && !busy;
    assign branch_target = pc + dec_imm;
    assign is_link       = (dec_iclass == cls_jal) || (dec_iclass == cls_jalr);

    // *******************************************************************
    // write-back
    // next_pc still holds pc + 4 during execute, which is the link value
    assign rf_we    = (state == st_exec && (dec_iclass == cls_alu || is_link)) ||
                      (state == st_mem && seq_done && dec_iclass == cls_load);
    assign rf_wdata = (state == st_mem) ? seq_rdata : (is_link ? next_pc : alu_result);

    // *******************************************************************
    // control FSM
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= st_fetch;
            busy    <= 1'b0;
            trap    <= 1'b0;
            pc      <= `RV_RESET_ADDR;
            next_pc <= `RV_RESET_ADDR;
        end else begin
            if (seq_start)
                busy <= 1'b1;
            case (state)
                st_fetch: if (seq_done) begin
                    busy  <= 1'b0;
                    pc    <= next_pc;
                    state <= st_decode;
                end
                st_decode: begin
                    next_pc <= pc + `RV_XLEN'd4;
                    if (dec_iclass == cls_illegal) begin
                        trap  <= 1'b1;
                        state <= st_trap;
                    end else begin
                        state <= st_load_ops;
                    end
                end
                st_load_ops:
                    state <= st_exec;
                st_exec: begin
                    state <= st_fetch;
                    case (dec_iclass)
                        cls_jal:             next_pc <= branch_target;
                        cls_jalr:            next_pc <= {alu_result[`RV_XLEN-1:1], 1'b0};
                        cls_branch:          if (alu_cond) next_pc <= branch_target;
                        cls_load, cls_store: state <= st_mem;
                        default: ;
                    endcase
                end
                st_mem: if (seq_done) begin
                    busy  <= 1'b0;
                    state <= st_fetch;
                end
                // trap holds until reset
                default: trap <= 1'b1;
            endcase
        end
    end

    // operand and result registers
    always_ff @(posedge clk) begin
        if (state == st_load_ops) begin
            op1 <= dec_use_pc ? pc : rf_rdata1;
            op2 <= dec_use_imm ? dec_imm : rf_rdata2;
        end
        if (state == st_exec)
            result <= alu_result;
    end

endmodule

/* rtl/rv_decoder.sv */
`timescale 1ns/1ns
`include "rv_core_defs.svh"

module rv_decoder import rv_isa_pkg::*; import rv_bus_pkg::*; (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     load,
    input  logic [`RV_XLEN-1:0]      instr,
    output instr_class_t             iclass,
    output alu_op_t                  alu_op,
    output logic [`RV_REG_IDX_W-1:0] rd,
    output logic [`RV_REG_IDX_W-1:0] rs1,
    output logic [`RV_REG_IDX_W-1:0] rs2,
    output logic [`RV_XLEN-1:0]      imm,
    output mem_size_t                mem_size,
    output logic                     load_unsigned,
    output logic                     use_pc,
    output logic                     use_imm
);

    opcode_t             opcode;
    funct3_t             funct3;
    funct7_t             funct7;
    instr_class_t        cls_d;
    alu_op_t             op_d;
    logic [`RV_XLEN-1:0] imm_d;
    logic                use_pc_d;
    logic                use_imm_d;
    logic                is_shift;

    function automatic alu_op_t arith_op(input funct3_t f3);
        case (f3)
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b110:  arith_op = alu_or;
            3'b111:  arith_op = alu_and;
            default: arith_op = alu_add;
        endcase
    endfunction

    assign opcode   = opcode_t'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

    always_comb begin
        cls_d     = cls_illegal;
        op_d      = alu_add;
        imm_d     = {{20{instr[31]}}, instr[31:20]};
        use_pc_d  = 1'b0;
        use_imm_d = 1'b1;
        case (opcode)
            opc_lui, opc_auipc: begin
                cls_d    = cls_alu;
                imm_d    = {instr[31:12], 12'b0};
                use_pc_d = (opcode == opc_auipc);
            end
            opc_jal: begin
                cls_d    = cls_jal;
                imm_d    = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
                use_pc_d = 1'b1;
            end
            opc_jalr:
                cls_d = (funct3 == 3'b000) ? cls_jalr : cls_illegal;
            opc_branch: begin
                cls_d     = cls_branch;
                imm_d     = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                             instr[11:8], 1'b0};
                use_imm_d = 1'b0;
                case (funct3)
                    3'b000:  op_d = alu_eq;
                    3'b001:  op_d = alu_ne;
                    3'b100:  op_d = alu_lt;
                    3'b101:  op_d = alu_ge;
                    3'b110:  op_d = alu_ltu;
                    3'b111:  op_d = alu_geu;
                    default: cls_d = cls_illegal;
                endcase
            end
            opc_load:
                cls_d = (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) ?
                        cls_load : cls_illegal;
            opc_store: begin
                cls_d = (funct3 inside {3'b000, 3'b001, 3'b010}) ? cls_store : cls_illegal;
                imm_d = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            opc_op_imm: begin
                cls_d = is_shift ? cls_illegal : cls_alu;
                op_d  = arith_op(funct3);
            end
            opc_op: begin
                use_imm_d = 1'b0;
                op_d      = (funct3 == 3'b000 && funct7 == f7_alt) ? alu_sub : arith_op(funct3);
                if (!is_shift && (funct7 == f7_base || (funct7 == f7_alt && funct3 == 3'b000)))
                    cls_d = cls_alu;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            iclass <= cls_illegal;
        end else if (load) begin
            iclass <= cls_d;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            alu_op        <= op_d;
            rd            <= instr[11:7];
            // lui reads x0 so the adder passes the immediate through
            rs1           <= (opcode == opc_lui) ? '0 : instr[19:15];
            rs2           <= instr[24:20];
            imm           <= imm_d;
            mem_size      <= (funct3[1:0] == 2'b00) ? size_byte :
                             (funct3[1:0] == 2'b01) ? size_half : size_word;
            load_unsigned <= funct3[2];
            use_pc        <= use_pc_d;
            use_imm       <= use_imm_d;
        end
    end

endmodule

/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011
    } opcode_t;

    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    localparam funct7_t f7_base = 7'b0000000;
    localparam funct7_t f7_alt  = 7'b0100000;

    // arithmetic ops first, branch compares after
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_xor, alu_or, alu_and,
        alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu
    } alu_op_t;

    typedef enum logic [2:0] {
        cls_alu,
        cls_branch,
        cls_jal,
        cls_jalr,
        cls_load,
        cls_store,
        cls_illegal
    } instr_class_t;

endpackage

/* rtl/rv_mem_sequencer.sv */
`timescale 1ns/1ns
`include "rv_core_defs.svh"

module rv_mem_sequencer import rv_bus_pkg::*; (
    input  logic                clk,
    input  logic                resetn,
    input  logic                start,
    input  logic                write,
    input  logic                instr,
    input  mem_size_t           size,
    input  logic                load_unsigned,
    input  logic [`RV_XLEN-1:0] addr,
    input  logic [`RV_XLEN-1:0] wdata,
    output logic                done,
    output logic [`RV_XLEN-1:0] rdata,
    output logic                mem_valid,
    output logic                mem_instr,
    output logic [`RV_XLEN-1:0] mem_addr,
    output logic [`RV_XLEN-1:0] mem_wdata,
    output wstrb_t              mem_wstrb,
    input  logic                mem_ready,
    input  logic [`RV_XLEN-1:0] mem_rdata
);

    typedef enum logic [1:0] {seq_idle, seq_read, seq_write} seq_state_t;

    seq_state_t          state;
    mem_size_t           size_q;
    logic [1:0]          lo_q;
    logic                unsigned_q;
    logic [`RV_XLEN-1:0] lanes;
    wstrb_t              strb;
    logic [7:0]          rd_byte;
    logic [15:0]         rd_half;
    logic [`RV_XLEN-1:0] rd_ext;

    // *******************************************************************
    // store lanes and strobes
    always_comb begin
        case (size)
            size_byte: begin
                lanes = {4{wdata[7:0]}};
                strb  = wstrb_t'(4'b0001 << addr[1:0]);
            end
            size_half: begin
                lanes = {2{wdata[15:0]}};
                strb  = addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                lanes = wdata;
                strb  = 4'b1111;
            end
        endcase
    end

    // *******************************************************************
    // load lane select and extension
    assign rd_byte = mem_rdata[8*lo_q +: 8];
    assign rd_half = lo_q[1] ? mem_rdata[31:16] : mem_rdata[15:0];

    always_comb begin
        case (size_q)
            size_byte: rd_ext = {{(`RV_XLEN-8){rd_byte[7] & !unsigned_q}}, rd_byte};
            size_half: rd_ext = {{(`RV_XLEN-16){rd_half[15] & !unsigned_q}}, rd_half};
            default:   rd_ext = mem_rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= seq_idle;
            mem_valid <= 1'b0;
            mem_wstrb <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (state == seq_idle) begin
                if (start) begin
                    mem_valid <= 1'b1;
                    mem_wstrb <= write ? strb : '0;
                    state     <= write ? seq_write : seq_read;
                end
            end else if (mem_ready) begin
                mem_valid <= 1'b0;
                mem_wstrb <= '0;
                done      <= 1'b1;
                state     <= seq_idle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == seq_idle && start) begin
            mem_addr   <= {addr[`RV_XLEN-1:2], 2'b00};
            mem_wdata  <= lanes;
            mem_instr  <= instr;
            size_q     <= size;
            lo_q       <= addr[1:0];
            unsigned_q <= load_unsigned;
        end
        if (state == seq_read && mem_ready) begin
            rdata <= rd_ext;
        end
    end

endmodule

/* rtl/rv_regfile.sv */
`timescale 1ns/1ns
`include "rv_core_defs.svh"

module rv_regfile (
    input  logic                     clk,
    input  logic                     we,
    input  logic [`RV_REG_IDX_W-1:0] waddr,
    input  logic [`RV_XLEN-1:0]      wdata,
    input  logic [`RV_REG_IDX_W-1:0] raddr1,
    input  logic [`RV_REG_IDX_W-1:0] raddr2,
    output logic [`RV_XLEN-1:0]      rdata1,
    output logic [`RV_XLEN-1:0]      rdata2
);

    logic [`RV_XLEN-1:0] regs [0:`RV_NREGS-1];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // index zero reads as constant zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f rv_core.f --top-module rv_core_tb

out=$(./obj_dir/Vrv_core_tb)
echo "$out"

if grep -qF '*** PASSED ***' <<< "$out"; then
    exit 0
else
    exit 1
fi

/* rv_core.f */
+incdir+include
rtl/rv_isa_pkg.sv
rtl/rv_bus_pkg.sv
rtl/rv_decoder.sv
rtl/rv_alu.sv
rtl/rv_regfile.sv
rtl/rv_mem_sequencer.sv
rtl/rv_core.sv
bench/rv_core_properties.sv
bench/rv_core_tb.sv
